// ==== Bender.yml ====
package:
  name: scroll_layer

sources:
  # tile scroll layer, package first
  - files:
      - design/scroll_pkg.sv
      - design/scroll_regs.sv
      - design/tile_fetch.sv
      - design/line_buffer.sv
      - design/scroll_layer.sv

  # testbench, top module scroll_tb
  - target: test
    files:
      - verif/scroll_assertions.sv
      - verif/scroll_tb.sv

// ==== design/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer import scroll_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              lhbl,
    input  wire buf_wr_t           buf_wr,
    input  wire logic [8:0]        hdump,
    output logic [pxl_w-1:0]       pxl
);

    logic [pxl_w-1:0] mem [2][line_w];   // two line halves
    logic             lhbl_l;
    logic             wr_half;           // half the fetcher fills
    logic             rd_half;           // half the display reads
    logic [1:0]       filled;            // half has been written since reset
    logic [pxl_w-1:0] rd_word;

    assign rd_half = ~wr_half;
    assign rd_word = mem[rd_half][hdump];

    // half swap and output register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l  <= 1'b0;
            wr_half <= 1'b0;
            filled  <= '0;
            pxl     <= '0;
        end else begin
            lhbl_l <= lhbl;
            if (lhbl_l && !lhbl) begin
                wr_half <= ~wr_half;   // swap at blank start
            end
            if (buf_wr.we) begin
                filled[wr_half] <= 1'b1;
            end
            // a half never written holds no valid line
            pxl <= filled[rd_half] ? rd_word : '0;
        end
    end

    // each half either takes fetcher writes or gets erased behind the display
    for (genvar h = 0; h < 2; h++) begin : g_half
        always_ff @(posedge clk) begin
            if (wr_half == 1'(h)) begin
                if (buf_wr.we) begin
                    mem[h][buf_wr.addr] <= buf_wr.data;
                end
            end else begin
                mem[h][hdump] <= '0;   // read above, cleared here
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/scroll_layer.sv ====
`timescale 1ns/1ps
`default_nettype none

module scroll_layer import scroll_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    // CPU
    input  wire logic               reg_we,
    input  wire reg_sel_e           reg_sel,
    input  wire logic [15:0]        reg_wdata,
    // video timing
    input  wire logic               lhbl,
    input  wire logic [8:0]         vrender,
    input  wire logic [8:0]         hdump,
    // map memory
    output logic [map_aw-1:0]       map_addr,
    input  wire logic [15:0]        map_data,
    input  wire logic               map_ok,
    // tile memory
    output logic [tile_aw-1:0]      tile_addr,
    input  wire logic [31:0]        tile_data,
    input  wire logic               tile_ok,
    // video out
    output logic [pxl_w-1:0]        pxl
);

    scroll_cfg_t cfg;          // shadowed scroll settings
    logic        line_start;
    buf_wr_t     buf_wr;       // fetcher to line buffer

    scroll_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_we     (reg_we),
        .reg_sel    (reg_sel),
        .reg_wdata  (reg_wdata),
        .lhbl       (lhbl),
        .cfg        (cfg),
        .line_start (line_start)
    );

    tile_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .line_start (line_start),
        .vrender    (vrender),
        .map_addr   (map_addr),
        .map_data   (map_data),
        .map_ok     (map_ok),
        .tile_addr  (tile_addr),
        .tile_data  (tile_data),
        .tile_ok    (tile_ok),
        .buf_wr     (buf_wr)
    );

    line_buffer u_lbuf (
        .clk        (clk),
        .rst        (rst),
        .lhbl       (lhbl),
        .buf_wr     (buf_wr),
        .hdump      (hdump),
        .pxl        (pxl)
    );

endmodule

`default_nettype wire

// ==== design/scroll_pkg.sv ====
`default_nettype none

package scroll_pkg;

    // line and tile geometry
    localparam int line_w  = 512;              // positions written per line
    localparam int buf_aw  = $clog2(line_w);   // line buffer address bits
    localparam int tile_w  = 8;                // pixels in one tile row

    // memory address widths
    localparam int map_aw  = 14;   // page(3) + row(5) + column(6)
    localparam int tile_aw = 17;   // bank + code + row + 0

    // 8 attribute bits on top of 3 colour bits
    localparam int pxl_w   = 11;

    // CPU register select
    typedef enum logic [1:0] {
        sel_pages = 2'd0,
        sel_hscr  = 2'd1,
        sel_vscr  = 2'd2
    } reg_sel_e;

    // fetcher FSM
    typedef enum logic [1:0] {
        st_idle  = 2'd0,   // line done, waiting for line_start
        st_map   = 2'd1,   // map entry read
        st_tile  = 2'd2,   // tile row read
        st_shift = 2'd3    // one pixel per clock into the line buffer
    } fetch_st_e;

    // scroll settings as seen by the fetcher
    typedef struct packed {
        logic [15:0] pages;   // four 3-bit page numbers, one per nibble
        logic [8:0]  hscr;
        logic [7:0]  vscr;
    } scroll_cfg_t;

    // map word after decode
    typedef struct packed {
        logic        bank;
        logic [7:0]  attr;    // palette bits, go out with each pixel
        logic [11:0] code;
    } map_entry_t;

    typedef struct packed {
        logic              we;
        logic [buf_aw-1:0] addr;
        logic [pxl_w-1:0]  data;
    } buf_wr_t;

endpackage

`default_nettype wire

// ==== design/scroll_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module scroll_regs import scroll_pkg::*; (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        reg_we,
    input  wire reg_sel_e    reg_sel,
    input  wire logic [15:0] reg_wdata,
    input  wire logic        lhbl,
    output scroll_cfg_t      cfg,
    output logic             line_start
);

    scroll_cfg_t live;      // what the CPU last wrote
    logic        lhbl_l;    // lhbl one clock late
    logic        hbl_fall;

    // blank begins when lhbl drops
    assign hbl_fall = lhbl_l & ~lhbl;

    // CPU side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            live <= '0;
        end else if (reg_we) begin
            case (reg_sel)
                sel_pages: live.pages <= reg_wdata;
                sel_hscr:  live.hscr  <= reg_wdata[8:0];
                sel_vscr:  live.vscr  <= reg_wdata[7:0];
                default: ;  // unused select code
            endcase
        end
    end

    // shadow copy taken once per line
    // so the fetcher sees the same scroll for the whole line
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l     <= 1'b0;
            cfg        <= '0;
            line_start <= 1'b0;
        end else begin
            lhbl_l     <= lhbl;
            line_start <= hbl_fall;   // high while the new cfg is already out
            if (hbl_fall) begin
                cfg <= live;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/tile_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_fetch import scroll_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire scroll_cfg_t        cfg,
    input  wire logic               line_start,
    input  wire logic [8:0]         vrender,
    output logic [map_aw-1:0]       map_addr,
    input  wire logic [15:0]        map_data,
    input  wire logic               map_ok,
    output logic [tile_aw-1:0]      tile_addr,
    input  wire logic [31:0]        tile_data,
    input  wire logic               tile_ok,
    output buf_wr_t                 buf_wr
);

    fetch_st_e  st;
    logic       issued;                  // address for this state is out
    logic [8:0] vline;                   // line being fetched
    logic [buf_aw-1:0] wpos;             // line buffer write position

    map_entry_t entry_d;                 // straight from the map bus
    map_entry_t entry;                   // held for tile read and pixels
    logic [7:0] plane2, plane1, plane0;  // msb is the next pixel

    logic [9:0] hsum;                    // scrolled horizontal position
    logic [8:0] vsum;                    // scrolled vertical position
    logic       hov, vov;
    logic [2:0] page;
    logic [2:0] hfine;                   // column inside the tile
    logic       tile_end;

    // scrolled position
    assign hsum  = {1'b0, wpos} + {1'b0, cfg.hscr};
    assign vsum  = vline + {1'b0, cfg.vscr};
    assign hov   = hsum[9];
    assign vov   = vsum[8];
    assign hfine = hsum[2:0];

    // last column of the tile row
    assign tile_end = hfine == 3'(tile_w - 1);

    // quadrant picks the page
    always_comb begin
        case ({vov, hov})
            2'b10:   page = cfg.pages[14:12];   // upper left
            2'b11:   page = cfg.pages[10:8];    // upper right
            2'b00:   page = cfg.pages[6:4];     // lower left
            default: page = cfg.pages[2:0];     // lower right
        endcase
    end

    // map word fields
    assign entry_d = '{
        bank: map_data[13],
        attr: map_data[12:5],
        code: map_data[11:0]
    };

    // one write per clock while shifting
    assign buf_wr = '{
        we:   st == st_shift,
        addr: wpos,
        data: {entry.attr, plane2[7], plane1[7], plane0[7]}
    };

    // control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st        <= st_idle;
            issued    <= 1'b0;
            vline     <= '0;
            wpos      <= '0;
            map_addr  <= '0;
            tile_addr <= '0;
        end else if (line_start) begin
            // new line restarts from position 0
            st     <= st_map;
            issued <= 1'b0;
            vline  <= vrender;
            wpos   <= '0;
        end else begin
            case (st)
                st_map: begin
                    if (!issued) begin
                        map_addr <= {page, vsum[7:3], hsum[8:3]};
                        issued   <= 1'b1;
                    end else if (map_ok) begin
                        issued <= 1'b0;
                        st     <= st_tile;
                    end
                end
                st_tile: begin
                    if (!issued) begin
                        tile_addr <= {entry.bank, entry.code, vsum[2:0], 1'b0};
                        issued    <= 1'b1;
                    end else if (tile_ok) begin
                        issued <= 1'b0;
                        st     <= st_shift;
                    end
                end
                st_shift: begin
                    wpos <= wpos + 1'b1;
                    if (&wpos) begin
                        st <= st_idle;       // 511 written, line complete
                    end else if (tile_end) begin
                        st <= st_map;        // next tile
                    end
                end
                default: ;  // idle until line_start
            endcase
        end
    end

    // map entry capture
    always_ff @(posedge clk) begin
        if (st == st_map && issued && map_ok) begin
            entry <= entry_d;
        end
    end

    // plane shifters
    // the load drops the columns left of the scroll position,
    // which only matters for the first tile of a line
    always_ff @(posedge clk) begin
        if (st == st_tile && issued && tile_ok) begin
            plane2 <= tile_data[23:16] << hfine;
            plane1 <= tile_data[15:8]  << hfine;
            plane0 <= tile_data[7:0]   << hfine;
        end else if (st == st_shift) begin
            plane2 <= plane2 << 1;
            plane1 <= plane1 << 1;
            plane0 <= plane0 << 1;
        end
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/scroll_pkg.sv
design/scroll_regs.sv
design/tile_fetch.sv
design/line_buffer.sv
design/scroll_layer.sv
verif/scroll_assertions.sv
verif/scroll_tb.sv

// ==== verif/scroll_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module scroll_assertions import scroll_pkg::*; (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              line_start,
    input  wire fetch_st_e         st,
    input  wire logic              issued,
    input  wire logic [map_aw-1:0] map_addr,
    input  wire logic              map_ok,
    input  wire buf_wr_t           buf_wr
);

    logic              seen_start;   // a line has been started since reset
    logic [buf_aw-1:0] next_addr;    // where the next write has to land
    int                fail_cnt = 0; // read by the testbench at the end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_start <= 1'b0;
            next_addr  <= '0;
        end else begin
            if (line_start) begin
                seen_start <= 1'b1;
                next_addr  <= '0;           // every line fills from 0
            end else if (buf_wr.we) begin
                next_addr  <= buf_wr.addr + 1'b1;
            end
        end
    end

    // fetcher quiet until the first line is started
    a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
        !seen_start |-> !buf_wr.we)
        else begin
            fail_cnt++;
            $error("line buffer written before the first line_start");
        end

    // map address held while the map read is pending
    a_map_addr_held: assert property (@(posedge clk) disable iff (rst)
        (st == st_map && issued && !map_ok) |=> $stable(map_addr))
        else begin
            fail_cnt++;
            $error("map_addr moved while map_ok was low");
        end

    // writes walk the line one position at a time
    a_wr_addr_step: assert property (@(posedge clk) disable iff (rst)
        (buf_wr.we && !line_start) |-> buf_wr.addr == next_addr)
        else begin
            fail_cnt++;
            $error("line buffer write address skipped a position");
        end

endmodule

`default_nettype wire

// ==== verif/scroll_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module scroll_tb import scroll_pkg::*; ();

    // one table row per scroll setting
    typedef struct packed {
        logic [15:0] pages;
        logic [8:0]  hscr;
        logic [7:0]  vscr;
        logic [8:0]  vstart;   // vrender of the first line
        logic [7:0]  lines;
    } stim_row_t;

    // what a fetch was started with, kept until it is on screen
    typedef struct packed {
        logic        valid;
        scroll_cfg_t cfg;
        logic [8:0]  v;
    } line_rec_t;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic reg_we;
    reg_sel_e reg_sel;
    logic [15:0] reg_wdata;
    logic lhbl = 1'b1;
    logic [8:0] vrender;
    logic [8:0] hdump = '0;
    logic [map_aw-1:0] map_addr;
    logic [15:0] map_data = '0;
    logic map_ok;
    logic [tile_aw-1:0] tile_addr;
    logic [31:0] tile_data = '0;
    logic tile_ok;
    logic [pxl_w-1:0] pxl;

    logic [15:0] map_mem [1 << map_aw];
    logic [31:0] tile_mem [1 << tile_aw];
    integer seed = 88;

    logic [10:0] hcnt = '0;                // clock inside the 1280-clock line
    logic [10:0] hnext;
    logic [map_aw-1:0] map_lat = '1;       // address the map model is serving
    logic [tile_aw-1:0] tile_lat = '1;
    logic [1:0] map_wait = '0, tile_wait = '0;
    logic map_okr = 1'b0, tile_okr = 1'b0;
    logic [1:0] map_extra, tile_extra;

    stim_row_t rows [5];
    scroll_cfg_t model_live = '0;          // registers as the CPU wrote them
    line_rec_t pending = '0;               // fetch in progress
    line_rec_t shown = '0;                 // fetch being displayed
    logic [pxl_w-1:0] exp_pxl;
    int err_cnt = 0;
    int n_checks = 0;
    int cyc = 0;
    int cyc_limit = 0;

    scroll_layer dut0 (.*);

    bind tile_fetch scroll_assertions chk0 (
        .clk(clk), .rst(rst), .line_start(line_start), .st(st), .issued(issued),
        .map_addr(map_addr), .map_ok(map_ok), .buf_wr(buf_wr)
    );

    always #5 clk = ~clk;

    // video timing, 640 visible clocks then 640 of blank
    assign hnext = (hcnt == 11'd1279) ? '0 : hcnt + 11'd1;
    always @(posedge clk) begin
        if (rst) begin
            hcnt  <= '0;
            lhbl  <= 1'b1;
            hdump <= '0;
        end else begin
            hcnt  <= hnext;
            lhbl  <= hnext < 11'd640;
            hdump <= (hnext < 11'd640) ? hnext[9:1] : 9'h1ff;  // parked off screen
        end
    end

    // ok follows the driven address 1 to 4 clocks later
    // dropped at once when the address moves on
    assign map_ok  = map_okr && (map_addr == map_lat);
    assign tile_ok = tile_okr && (tile_addr == tile_lat);

    always @(posedge clk) begin
        map_data <= map_mem[map_addr];
        if (rst) begin
            map_lat <= '1;
            map_okr <= 1'b0;
        end else if (map_addr != map_lat) begin
            map_extra = 2'($random(seed) & 3);
            map_lat  <= map_addr;
            map_wait <= map_extra;
            map_okr  <= map_extra == 2'd0;
        end else if (map_wait != 2'd0) begin
            map_wait <= map_wait - 2'd1;
            map_okr  <= map_wait == 2'd1;
        end
    end

    always @(posedge clk) begin
        tile_data <= tile_mem[tile_addr];
        if (rst) begin
            tile_lat <= '1;
            tile_okr <= 1'b0;
        end else if (tile_addr != tile_lat) begin
            tile_extra = 2'($random(seed) & 3);
            tile_lat  <= tile_addr;
            tile_wait <= tile_extra;
            tile_okr  <= tile_extra == 2'd0;
        end else if (tile_wait != 2'd0) begin
            tile_wait <= tile_wait - 2'd1;
            tile_okr  <= tile_wait == 2'd1;
        end
    end

    // pixel at screen column x from the map and tile arrays
    function automatic logic [pxl_w-1:0] ref_pixel(scroll_cfg_t c, logic [8:0] v,
                                                  logic [8:0] x);
        logic [9:0]  h;
        logic [8:0]  vs;
        logic [2:0]  pg;
        logic [15:0] mw;
        logic [31:0] td;
        logic [2:0]  col;
        h  = {1'b0, x} + {1'b0, c.hscr};
        vs = v + {1'b0, c.vscr};
        case ({vs[8], h[9]})          // quadrant
            2'b10:   pg = c.pages[14:12];
            2'b11:   pg = c.pages[10:8];
            2'b00:   pg = c.pages[6:4];
            default: pg = c.pages[2:0];
        endcase
        mw  = map_mem[{pg, vs[7:3], h[8:3]}];
        td  = tile_mem[{mw[13], mw[11:0], vs[2:0], 1'b0}];
        col = h[2:0];
        return {mw[12:5], td[23 - col], td[15 - col], td[7 - col]};
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        err_cnt++;
        $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
    endtask

    task automatic check_reset_state;
        assert (pxl == '0) else report_value("pxl", 32'd0, 32'(pxl));
        assert (map_addr == '0) else report_value("map_addr", 32'd0, 32'(map_addr));
        assert (tile_addr == '0) else report_value("tile_addr", 32'd0, 32'(tile_addr));
    endtask

    // returns on the edge that ends line clock n
    task automatic sync_to(input logic [10:0] n);
        do @(posedge clk); while (hcnt != n);
    endtask

    task automatic write_reg(input reg_sel_e sel, input logic [15:0] data);
        reg_we    <= 1'b1;
        reg_sel   <= sel;
        reg_wdata <= data;
        @(posedge clk);
    endtask

    // first blank clock: the line just shown is replaced by the one fetched last
    always @(posedge clk) begin
        if (!rst && hcnt == 11'd640) begin
            shown   <= pending;
            pending <= {1'b1, model_live, vrender};
        end
    end

    // pxl holds the entry for one clock, the second clock of each hdump step
    always @(negedge clk) begin
        if (!rst && hcnt < 11'd640 && hcnt[0]) begin
            exp_pxl = shown.valid ? ref_pixel(shown.cfg, shown.v, hcnt[9:1]) : '0;
            n_checks++;
            assert (pxl == exp_pxl) else report_value("pxl", 32'(exp_pxl), 32'(pxl));
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc_limit != 0 && cyc >= cyc_limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cyc_limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        int r;
        int l;
        int afail;
        reg_we    = 1'b0;
        reg_sel   = sel_pages;
        reg_wdata = '0;
        vrender   = '0;
        // pages, hscr, vscr, first vrender, lines
        rows[0] = {16'h0123, 9'd0,   8'h00, 9'd0,   8'd3};   // no scroll
        rows[1] = {16'h0123, 9'd3,   8'h00, 9'd40,  8'd2};   // fine horizontal scroll
        rows[2] = {16'h0123, 9'd509, 8'hf8, 9'd6,   8'd3};   // crosses both page edges
        rows[3] = {16'h4567, 9'd261, 8'h80, 9'd382, 8'd2};   // upper quadrants
        rows[4] = {16'h7654, 9'd183, 8'h33, 9'd510, 8'd2};   // vrender wraps
        for (int a = 0; a < (1 << map_aw); a++) begin
            map_mem[a] = 16'($random(seed));
        end
        for (int a = 0; a < (1 << tile_aw); a++) begin
            tile_mem[a] = $random(seed);
        end
        cyc_limit = 100;
        foreach (rows[i]) begin
            cyc_limit += (int'(rows[i].lines) + 2) * 1280;
        end

        @(posedge clk);
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        rst <= 1'b0;

        // writes land mid-line, while the previous fetch is still running
        for (r = 0; r < $size(rows); r++) begin
            sync_to(11'd99);
            vrender <= rows[r].vstart;
            write_reg(sel_pages, rows[r].pages);
            write_reg(sel_hscr, {7'd0, rows[r].hscr});
            write_reg(sel_vscr, {8'd0, rows[r].vscr});
            reg_we <= 1'b0;
            model_live = {rows[r].pages, rows[r].hscr, rows[r].vscr};
            for (l = 1; l <= int'(rows[r].lines); l++) begin
                sync_to(11'd1279);
                if (l < int'(rows[r].lines)) begin
                    vrender <= rows[r].vstart + 9'(l);
                end
            end
        end

        // last fetch is on screen in the line after next
        sync_to(11'd1279);
        sync_to(11'd639);
        @(posedge clk);

        afail = dut0.u_fetch.chk0.fail_cnt;
        $display("pixel checks %0d, value errors %0d, assertion failures %0d",
                 n_checks, err_cnt, afail);
        if (err_cnt == 0 && afail == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
